// File: rtl/edge_pkg.sv
package edge_pkg;

    // width of one feature value
    parameter int fv_w = 16;

    // bank_id fields are sized for up to this many banks
    parameter int max_pe = 8;
    parameter int bank_id_w = $clog2(max_pe);

    // 8 guard bits, so 256 beats of full-scale data cannot wrap
    parameter int sum_w = fv_w + 8;

    typedef logic [bank_id_w-1:0] bank_id_t;
    typedef logic [sum_w-1:0] sum_t;

    // one beat from an edge PE into its bank
    // done_aggr and wb_en only count on the eos beat
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
        logic [1:0][fv_w-1:0] fv_data;
        logic done_aggr;
        logic wb_en;
    } edge_pe2bank;

    // one beat from a bank to the reduction stage, all zero when idle
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
        bank_id_t bank_id;
        logic [1:0][fv_w-1:0] fv_data;
        logic done_aggr;
    } bank2rs;

    // one beat from a bank toward the output SRAM
    typedef struct packed {
        logic req;
        logic sos;
        logic eos;
        logic [1:0][fv_w-1:0] fv_data;
    } bank2osram;

    // one reduction result per message
    typedef struct packed {
        logic valid;
        bank_id_t bank_id;
        logic done_aggr;
        logic [1:0][sum_w-1:0] sum;
    } rs_result;

    // bank FSM states
    typedef enum logic [1:0] {
        st_fill,
        st_wait_rs,
        st_send_rs,
        st_send_wb
    } bank_state_t;

endpackage

// File: rtl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int num_pe = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic [num_pe-1:0] req,
    input  logic rs_busy,
    output logic [num_pe-1:0] grant
);

    // ptr marks the banks still eligible in this round
    logic [num_pe-1:0] ptr;
    logic [num_pe-1:0] mask_req;
    logic [num_pe-1:0] mask_win;
    logic [num_pe-1:0] full_win;
    logic [num_pe-1:0] win;
    logic [num_pe-1:0] next_ptr;

    always_comb begin
        mask_req = req & ptr;
        mask_win = '0;
        full_win = '0;
        // highest index wins, later iterations overwrite lower ones
        for (int i = 0; i < num_pe; i++) begin
            if (mask_req[i]) begin
                mask_win = '0;
                mask_win[i] = 1'b1;
            end
            if (req[i]) begin
                full_win = '0;
                full_win[i] = 1'b1;
            end
        end
        win = (|mask_req) ? mask_win : full_win;

        // after bank k only the banks below k stay eligible
        next_ptr = ptr;
        for (int i = 0; i < num_pe; i++) begin
            if (win[i]) begin
                next_ptr = (i == 0) ? '1 : num_pe'((1 << i) - 1);
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ptr <= '1;
            grant <= '0;
        end else begin
            // no grant while the reduction stage holds a message
            grant <= rs_busy ? '0 : win;
            if (!rs_busy) begin
                ptr <= next_ptr;
            end
        end
    end

endmodule

// File: rtl/edge_buffer_one.sv
`timescale 1ns/1ps

module edge_buffer_one #(
    parameter int buf_depth = 8,
    parameter int bank_id = 0
) (
    input  logic clk,
    input  logic reset,
    input  edge_pkg::edge_pe2bank edge_pkt,
    input  logic osram_grant,
    input  logic rs_grant,
    output logic rs_req,
    output edge_pkg::bank2rs rs_pkt,
    output logic bank_busy,
    output edge_pkg::bank2osram osram_pkt
);

    localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;

    edge_pkg::bank_state_t state;

    logic [1:0][edge_pkg::fv_w-1:0] mem [buf_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] wr_idx;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] last_idx;
    logic done_aggr_q;
    logic beat_in;
    logic rs_send;
    logic wb_send;
    logic last_beat;

    // a sos beat always lands in slot 0
    assign wr_idx = edge_pkt.sos ? '0 : wr_ptr;
    assign beat_in = (state == edge_pkg::st_fill) && edge_pkt.valid;

    // first beat goes out in the grant cycle itself
    assign rs_send = ((state == edge_pkg::st_wait_rs) && rs_grant)
                     || (state == edge_pkg::st_send_rs);
    assign wb_send = (state == edge_pkg::st_send_wb) && osram_grant;
    assign last_beat = (rd_ptr == last_idx);

    assign rs_req = (state == edge_pkg::st_wait_rs);
    assign bank_busy = (state != edge_pkg::st_fill);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= edge_pkg::st_fill;
            wr_ptr <= '0;
            rd_ptr <= '0;
            last_idx <= '0;
            done_aggr_q <= 1'b0;
        end else begin
            if (beat_in) begin
                wr_ptr <= wr_idx + ptr_w'(1);
                if (edge_pkt.eos) begin
                    last_idx <= wr_idx;
                    done_aggr_q <= edge_pkt.done_aggr;
                    rd_ptr <= '0;
                    state <= edge_pkt.wb_en ? edge_pkg::st_send_wb : edge_pkg::st_wait_rs;
                end
            end
            if (rs_send || wb_send) begin
                rd_ptr <= rd_ptr + ptr_w'(1);
                if (last_beat) begin
                    state <= edge_pkg::st_fill;
                end else if (rs_send) begin
                    state <= edge_pkg::st_send_rs;
                end
            end
        end
    end

    // beat storage
    always_ff @(posedge clk) begin
        if (beat_in) begin
            mem[wr_idx] <= edge_pkt.fv_data;
        end
    end

    always_comb begin
        rs_pkt = '0;
        if (rs_send) begin
            rs_pkt.valid = 1'b1;
            rs_pkt.sos = (rd_ptr == '0);
            rs_pkt.eos = last_beat;
            rs_pkt.bank_id = edge_pkg::bank_id_t'(bank_id);
            rs_pkt.fv_data = mem[rd_ptr];
            rs_pkt.done_aggr = done_aggr_q;
        end
    end

    // write-back beat held until the SRAM side grants it
    always_comb begin
        osram_pkt = '0;
        if (state == edge_pkg::st_send_wb) begin
            osram_pkt.req = 1'b1;
            osram_pkt.sos = (rd_ptr == '0);
            osram_pkt.eos = last_beat;
            osram_pkt.fv_data = mem[rd_ptr];
        end
    end

endmodule

// File: rtl/edge_buffer.sv
`timescale 1ns/1ps

module edge_buffer #(
    parameter int num_pe = 4,
    parameter int buf_depth = 8
) (
    input  logic clk,
    input  logic reset,
    input  edge_pkg::edge_pe2bank [num_pe-1:0] edge_pkt,
    input  logic [num_pe-1:0] osram_grant,
    input  logic rs_busy,
    output edge_pkg::bank2rs rs_pkt,
    output logic [num_pe-1:0] bank_busy,
    output logic busy,
    output edge_pkg::bank2osram [num_pe-1:0] osram_pkt
);

    logic [num_pe-1:0] rs_req;
    logic [num_pe-1:0] rs_grant;
    edge_pkg::bank2rs [num_pe-1:0] bank_pkt;

    for (genvar i = 0; i < num_pe; i++) begin : g_bank
        edge_buffer_one #(
            .buf_depth(buf_depth),
            .bank_id(i)
        ) u_bank (
            .clk(clk),
            .reset(reset),
            .edge_pkt(edge_pkt[i]),
            .osram_grant(osram_grant[i]),
            .rs_grant(rs_grant[i]),
            .rs_req(rs_req[i]),
            .rs_pkt(bank_pkt[i]),
            .bank_busy(bank_busy[i]),
            .osram_pkt(osram_pkt[i])
        );
    end

    rr_arbiter #(
        .num_pe(num_pe)
    ) u_arb (
        .clk(clk),
        .reset(reset),
        .req(rs_req),
        .rs_busy(rs_busy),
        .grant(rs_grant)
    );

    // idle banks drive zero, so a plain OR picks the sender
    always_comb begin
        rs_pkt = '0;
        for (int i = 0; i < num_pe; i++) begin
            rs_pkt = rs_pkt | bank_pkt[i];
        end
    end

    assign busy = |bank_busy;

endmodule

// File: rtl/reduction_stage.sv
`timescale 1ns/1ps

module reduction_stage (
    input  logic clk,
    input  logic reset,
    input  edge_pkg::bank2rs rs_pkt,
    output logic rs_busy,
    output edge_pkg::rs_result result
);

    logic in_prog;
    logic [1:0][edge_pkg::sum_w-1:0] acc;
    logic [1:0][edge_pkg::sum_w-1:0] acc_next;

    logic res_valid;
    edge_pkg::bank_id_t res_bank_id;
    logic res_done;
    logic [1:0][edge_pkg::sum_w-1:0] res_sum;

    // busy for the whole message, including its first beat
    assign rs_busy = rs_pkt.valid | in_prog;

    // sos restarts both lanes from the beat data
    always_comb begin
        for (int l = 0; l < 2; l++) begin
            acc_next[l] = (rs_pkt.sos ? '0 : acc[l])
                          + edge_pkg::sum_t'(rs_pkt.fv_data[l]);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_prog <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= rs_pkt.valid && rs_pkt.eos;
            if (rs_pkt.valid) begin
                in_prog <= !rs_pkt.eos;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rs_pkt.valid) begin
            acc <= acc_next;
        end
        // capture the result on the closing beat
        if (rs_pkt.valid && rs_pkt.eos) begin
            res_bank_id <= rs_pkt.bank_id;
            res_done <= rs_pkt.done_aggr;
            res_sum <= acc_next;
        end
    end

    always_comb begin
        result.valid = res_valid;
        result.bank_id = res_bank_id;
        result.done_aggr = res_done;
        result.sum = res_sum;
    end

endmodule

// File: rtl/edge_aggr_top.sv
`timescale 1ns/1ps

module edge_aggr_top #(
    parameter int num_pe = 4,
    parameter int buf_depth = 8
) (
    input  logic clk,
    input  logic reset,
    input  edge_pkg::edge_pe2bank [num_pe-1:0] pe_pkt,
    input  logic [num_pe-1:0] osram_grant,
    output edge_pkg::bank2osram [num_pe-1:0] osram_pkt,
    output edge_pkg::rs_result result,
    output logic [num_pe-1:0] bank_busy,
    output logic busy
);

    // merged bank traffic into the reduction stage
    edge_pkg::bank2rs rs_pkt;
    logic rs_busy;

    edge_buffer #(
        .num_pe(num_pe),
        .buf_depth(buf_depth)
    ) u_edge_buffer (
        .clk(clk),
        .reset(reset),
        .edge_pkt(pe_pkt),
        .osram_grant(osram_grant),
        .rs_busy(rs_busy),
        .rs_pkt(rs_pkt),
        .bank_busy(bank_busy),
        .busy(busy),
        .osram_pkt(osram_pkt)
    );

    reduction_stage u_rs (
        .clk(clk),
        .reset(reset),
        .rs_pkt(rs_pkt),
        .rs_busy(rs_busy),
        .result(result)
    );

endmodule

// File: verification/edge_aggr_tb.sv
`timescale 1ns/1ps

module edge_aggr_tb;

    localparam int num_pe = 4;
    localparam int buf_depth = 8;
    localparam int num_msgs = 300;
    // generous bound for one message including gaps and grant stalls
    localparam int msg_cycles = 4 * buf_depth + 8;
    localparam int test_cycles = 8 + (2 + num_pe + num_msgs) * msg_cycles;

    typedef struct packed {
        logic [1:0][edge_pkg::sum_w-1:0] sum;
        logic done;
        int len;
        int eos_cyc;
    } exp_res_t;

    logic clk = 1'b0;
    logic reset;
    edge_pkg::edge_pe2bank [num_pe-1:0] pe_pkt;
    logic [num_pe-1:0] osram_grant;
    edge_pkg::bank2osram [num_pe-1:0] osram_pkt;
    edge_pkg::rs_result result;
    logic [num_pe-1:0] bank_busy;
    logic busy;

    // reference model state
    logic [1:0][edge_pkg::fv_w-1:0] stage_q [num_pe][$];
    logic [33:0] wb_q [num_pe][$];
    exp_res_t res_q [num_pe][$];
    logic [num_pe-1:0] exp_busy;
    int order_q [$];
    int cyc;
    int last_res_cyc;
    int res_count;
    int errors;
    int err_mark;
    int tests_failed;
    bit check_lat;
    bit record_order;

    edge_aggr_top #(
        .num_pe(num_pe),
        .buf_depth(buf_depth)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .pe_pkt(pe_pkt),
        .osram_grant(osram_grant),
        .osram_pkt(osram_pkt),
        .result(result),
        .bank_busy(bank_busy),
        .busy(busy)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Fail %s: got 0x%0h expected 0x%0h at cycle %0d", sig, got, exp, cyc);
        errors = errors + 1;
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s at cycle %0d", msg, cyc);
        errors = errors + 1;
    endtask

    function automatic int pending();
        int total;
        total = 0;
        for (int b = 0; b < num_pe; b++) begin
            total = total + res_q[b].size() + wb_q[b].size();
        end
        return total;
    endfunction

    function automatic edge_pkg::edge_pe2bank random_beat(input bit sos, input bit eos,
                                                          input bit wb);
        edge_pkg::edge_pe2bank pkt;
        pkt = '0;
        pkt.valid = 1'b1;
        pkt.sos = sos;
        pkt.eos = eos;
        pkt.fv_data = $urandom;
        pkt.done_aggr = 1'($urandom_range(0, 1));
        pkt.wb_en = wb;
        return pkt;
    endfunction

    // reference model and output checks on the rising edge
    always @(posedge clk) begin : monitor
        exp_res_t e;
        logic [33:0] w;
        logic [1:0][edge_pkg::fv_w-1:0] beat;
        int b;
        int last;
        if (reset) begin
            if (result.valid) begin
                b = int'(result.bank_id);
                res_count = res_count + 1;
                if (record_order) begin
                    order_q.push_back(b);
                end
                if (b >= num_pe || res_q[b].size() == 0) begin
                    report_error($sformatf("unexpected result from bank %0d", b));
                end else begin
                    e = res_q[b].pop_front();
                    assert (result.sum == e.sum)
                        else report_mismatch("result.sum", 64'(result.sum), 64'(e.sum));
                    assert (result.done_aggr == e.done)
                        else report_mismatch("result.done_aggr", 64'(result.done_aggr),
                                             64'(e.done));
                    if (check_lat) begin
                        assert (cyc - e.eos_cyc == e.len + 2)
                            else report_mismatch("result latency", 64'(cyc - e.eos_cyc),
                                                 64'(e.len + 2));
                    end
                    // one message at a time in the reduction stage
                    assert (cyc - last_res_cyc >= e.len)
                        else report_error("results closer than the message length");
                    exp_busy[b] = 1'b0;
                end
                last_res_cyc = cyc;
            end
            assert (busy == (|exp_busy))
                else report_mismatch("busy", 64'(busy), 64'(|exp_busy));
            for (int bb = 0; bb < num_pe; bb++) begin
                assert (bank_busy[bb] == exp_busy[bb])
                    else report_mismatch($sformatf("bank_busy[%0d]", bb), 64'(bank_busy[bb]),
                                         64'(exp_busy[bb]));
                if (osram_pkt[bb].req && osram_grant[bb]) begin
                    if (wb_q[bb].size() == 0) begin
                        report_error($sformatf("unexpected write-back beat on bank %0d", bb));
                    end else begin
                        w = wb_q[bb].pop_front();
                        assert ({osram_pkt[bb].sos, osram_pkt[bb].eos,
                                 osram_pkt[bb].fv_data} == w)
                            else report_mismatch($sformatf("osram_pkt[%0d]", bb),
                                                 64'({osram_pkt[bb].sos, osram_pkt[bb].eos,
                                                      osram_pkt[bb].fv_data}), 64'(w));
                        // expected eos bit closes the busy window
                        if (w[32]) begin
                            exp_busy[bb] = 1'b0;
                        end
                    end
                end
                // a beat is written only while the bank is filling
                if (pe_pkt[bb].valid && !bank_busy[bb]) begin
                    if (pe_pkt[bb].sos) begin
                        stage_q[bb].delete();
                    end
                    stage_q[bb].push_back(pe_pkt[bb].fv_data);
                    if (pe_pkt[bb].eos) begin
                        exp_busy[bb] = 1'b1;
                        last = stage_q[bb].size() - 1;
                        e = '0;
                        for (int k = 0; k <= last; k++) begin
                            beat = stage_q[bb][k];
                            if (pe_pkt[bb].wb_en) begin
                                wb_q[bb].push_back({k == 0, k == last, beat});
                            end
                            for (int l = 0; l < 2; l++) begin
                                e.sum[l] = e.sum[l] + edge_pkg::sum_t'(beat[l]);
                            end
                        end
                        if (!pe_pkt[bb].wb_en) begin
                            e.done = pe_pkt[bb].done_aggr;
                            e.len = last + 1;
                            e.eos_cyc = cyc;
                            res_q[bb].push_back(e);
                        end
                    end
                end
            end
            cyc = cyc + 1;
        end
    end

    task automatic check_idle();
        assert (bank_busy == '0)
            else report_mismatch("bank_busy", 64'(bank_busy), 64'(0));
        assert (!busy) else report_mismatch("busy", 64'(busy), 64'(0));
        assert (!result.valid) else report_mismatch("result.valid", 64'(result.valid), 64'(0));
        for (int b = 0; b < num_pe; b++) begin
            assert (!osram_pkt[b].req)
                else report_mismatch($sformatf("osram_pkt[%0d].req", b),
                                     64'(osram_pkt[b].req), 64'(0));
        end
    endtask

    // one message on one bank with random gaps between beats
    task automatic send_msg(input int b, input int n, input bit wb);
        int k;
        k = 0;
        while (k < n) begin
            @(negedge clk);
            pe_pkt[b] = '0;
            if ($urandom_range(0, 2) != 0) begin
                pe_pkt[b] = random_beat(k == 0, k == n - 1, wb);
                k = k + 1;
            end
        end
        @(negedge clk);
        pe_pkt[b] = '0;
    endtask

    // every bank ends its message on the same edge
    task automatic drive_contention();
        int len [num_pe];
        int maxl;
        int k;
        maxl = 0;
        for (int b = 0; b < num_pe; b++) begin
            len[b] = $urandom_range(1, buf_depth);
            if (len[b] > maxl) begin
                maxl = len[b];
            end
        end
        for (int t = 0; t < maxl; t++) begin
            @(negedge clk);
            for (int b = 0; b < num_pe; b++) begin
                k = t - (maxl - len[b]);
                pe_pkt[b] = (k >= 0) ? random_beat(k == 0, k == len[b] - 1, 1'b0) : '0;
            end
        end
        @(negedge clk);
        pe_pkt = '0;
    endtask

    task automatic drive_random_mix();
        int pos [num_pe];
        int len [num_pe];
        bit wb [num_pe];
        bit act [num_pe];
        int sent;
        int live;
        sent = 0;
        live = 0;
        for (int b = 0; b < num_pe; b++) begin
            act[b] = 1'b0;
        end
        while (sent < num_msgs || live != 0) begin
            @(negedge clk);
            for (int b = 0; b < num_pe; b++) begin
                pe_pkt[b] = '0;
                // new stream only on an idle bank
                if (!act[b] && !bank_busy[b] && sent < num_msgs && $urandom_range(0, 3) == 0) begin
                    act[b] = 1'b1;
                    pos[b] = 0;
                    len[b] = $urandom_range(1, buf_depth);
                    wb[b] = 1'($urandom_range(0, 1));
                    sent = sent + 1;
                    live = live + 1;
                end
                if (act[b] && $urandom_range(0, 3) != 0) begin
                    pe_pkt[b] = random_beat(pos[b] == 0, pos[b] == len[b] - 1, wb[b]);
                    pos[b] = pos[b] + 1;
                    if (pos[b] == len[b]) begin
                        act[b] = 1'b0;
                        live = live - 1;
                    end
                end
            end
            osram_grant = num_pe'($urandom);
        end
        @(negedge clk);
        pe_pkt = '0;
    endtask

    // drain with random SRAM grants until the model and the DUT are idle
    task automatic wait_idle();
        @(negedge clk);
        while (pending() != 0 || busy) begin
            osram_grant = num_pe'($urandom);
            @(negedge clk);
        end
        osram_grant = '0;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        if (errors != err_mark) begin
            tests_failed = tests_failed + 1;
        end
        err_mark = errors;
    endtask

    initial begin
        watchdog_wait: begin
            repeat (4 * test_cycles) @(posedge clk);
        end
        report_error("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int n;
        int mark;
        void'($urandom(32'hda68_29f7));
        reset = 1'b0;
        pe_pkt = '0;
        osram_grant = '0;
        exp_busy = '0;
        cyc = 0;
        last_res_cyc = -1000;
        res_count = 0;
        errors = 0;
        err_mark = 0;
        tests_failed = 0;
        check_lat = 1'b0;
        record_order = 1'b0;

        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b1;
        @(negedge clk);
        check_idle();
        report_test(1, "reset");

        // bank 0 leaves the arbiter pointer fully open
        mark = res_count;
        check_lat = 1'b1;
        n = $urandom_range(1, buf_depth);
        send_msg(0, n, 1'b0);
        wait_idle();
        check_lat = 1'b0;
        assert (res_count - mark == 1)
            else report_mismatch("result count", 64'(res_count - mark), 64'(1));
        report_test(2, "single reduction");

        mark = res_count;
        send_msg($urandom_range(0, num_pe - 1), $urandom_range(1, buf_depth), 1'b1);
        wait_idle();
        assert (res_count == mark)
            else report_mismatch("result count", 64'(res_count - mark), 64'(0));
        report_test(3, "write-back under back-pressure");

        order_q.delete();
        record_order = 1'b1;
        drive_contention();
        wait_idle();
        record_order = 1'b0;
        assert (order_q.size() == num_pe)
            else report_mismatch("result count", 64'(order_q.size()), 64'(num_pe));
        for (int k = 0; k < order_q.size(); k++) begin
            assert (order_q[k] == num_pe - 1 - k)
                else report_mismatch("result.bank_id", 64'(order_q[k]), 64'(num_pe - 1 - k));
        end
        report_test(4, "round-robin contention");

        drive_random_mix();
        wait_idle();
        report_test(5, "random mix");

        $display("tests run: 5, tests failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/edge_pkg.sv
rtl/rr_arbiter.sv
rtl/edge_buffer_one.sv
rtl/edge_buffer.sv
rtl/reduction_stage.sv
rtl/edge_aggr_top.sv
verification/edge_aggr_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the edge aggregation testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module edge_aggr_tb \
    -f all.f \
    -o sim_edge_aggr

./obj_dir/sim_edge_aggr | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
